// ==== design/renamePkg.sv ====
// Shared definitions for the retirement map and free list
// Register counts, index widths and the derived counter width
// Map packet struct used by the commit and recovery buses
// Recovery sequencer state enum
`default_nettype none

package renamePkg;

  localparam int NumLogRegs  = 32;  // Architectural registers
  localparam int NumPhysRegs = 64;  // Physical registers shared by map and free list
  localparam int CommitWidth = 4;   // Retiring instructions per cycle

  localparam int LogRegBits  = $clog2(NumLogRegs);
  localparam int PhysRegBits = $clog2(NumPhysRegs);

  // Occupancy counter must be able to hold the full count, not just an index
  localparam int FreeCntBits = $clog2(NumPhysRegs + 1);

  typedef logic [LogRegBits-1:0]  logRegT;   // Logical register index
  typedef logic [PhysRegBits-1:0] physRegT;  // Physical register index

  // One mapping: logical destination in the upper bits, physical register below
  typedef struct packed {
    logRegT  logDest;
    physRegT physReg;
  } mapPacketT;

  // Table either serves commits or streams its contents for a rebuild
  typedef enum logic {
    recIdle,
    recActive
  } recStateT;

endpackage

`default_nettype wire

// ==== design/amtWriteIf.sv ====
// Bus between the map table control logic and its register array
// Four write ports (enable, address, data) applied at the clock edge
// Four read ports with combinational data return
// Modports for the control side and the storage side
`default_nettype none

interface amtWriteIf;
  import renamePkg::*;

  logic    [CommitWidth-1:0] writeEn;    // One enable per commit slot
  logRegT  [CommitWidth-1:0] writeAddr;  // Logical destination being written
  physRegT [CommitWidth-1:0] writeData;  // New committed physical register

  logRegT  [CommitWidth-1:0] readAddr;   // Commit destinations or recovery group
  physRegT [CommitWidth-1:0] readData;   // Current committed mapping, same cycle

  // Control logic drives every address and gets the mappings back
  modport tableSide (
    output writeEn, writeAddr, writeData, readAddr,
    input  readData
  );

  // Array owns the read data and only listens to the rest
  modport storageSide (
    input  writeEn, writeAddr, writeData, readAddr,
    output readData
  );

endinterface

`default_nettype wire

// ==== design/releaseIf.sv ====
// Release bus from the map table into the free list
// Up to four freed physical registers per cycle, in slot order
// No back-pressure, the consumer takes all valid slots at the edge
`default_nettype none

interface releaseIf;
  import renamePkg::*;

  logic    [CommitWidth-1:0] relValid;  // Slot carries a freed register
  physRegT [CommitWidth-1:0] relPhys;   // Freed register for that slot

  // Map table side
  modport producer (
    output relValid, relPhys
  );

  // Free list side, pushes compacted valid slots at the tail
  modport consumer (
    input relValid, relPhys
  );

endinterface

`default_nettype wire

// ==== design/amtStorage.sv ====
// Committed architectural map storage
// Flip-flop array of physical register indices, one per logical register
// Four combinational read ports and four write ports, higher slot wins
// Reset loads the identity mapping
`default_nettype none

module amtStorage (
  input wire logic clk,
  input wire logic reset,
  amtWriteIf.storageSide port
);
  import renamePkg::*;

  physRegT mapTable [NumLogRegs];  // Logical index selects the committed mapping

  // Writes go in slot order, so a later slot would overwrite an earlier one
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NumLogRegs; i++) begin
        mapTable[i] <= physRegT'(i);  // Logical i starts on physical i
      end
    end else begin
      for (int w = 0; w < CommitWidth; w++) begin
        if (port.writeEn[w]) begin
          mapTable[port.writeAddr[w]] <= port.writeData[w];
        end
      end
    end
  end

  // Reads see the mapping before this cycle's writes
  always_comb begin
    for (int r = 0; r < CommitWidth; r++) begin
      port.readData[r] = mapTable[port.readAddr[r]];
    end
  end

  // The table filters same-destination slots, so enabled writes never collide
  generate
    for (genvar a = 0; a < CommitWidth; a++) begin : gWriteA
      for (genvar b = a + 1; b < CommitWidth; b++) begin : gWriteB
        assert property (@(posedge clk) disable iff (reset)
          !(port.writeEn[a] && port.writeEn[b] &&
            (port.writeAddr[a] == port.writeAddr[b])))
          else $error("amtStorage: write ports %0d and %0d hit the same entry", a, b);
      end
    end
  endgenerate

endmodule

`default_nettype wire

// ==== design/archMapTable.sv ====
// Architectural map table control
// Same-destination filtering across the commit window
// Release selection for the free list
// Read-address selection between commit and recovery
// Recovery sequencer that streams four entries per cycle
`default_nettype none

module archMapTable (
  input  wire logic                                        clk,
  input  wire logic                                        reset,
  input  wire logic      [renamePkg::CommitWidth-1:0]      commitValid_i,
  input  wire renamePkg::mapPacketT [renamePkg::CommitWidth-1:0] commitPacket_i,
  input  wire logic                                        recoverStart_i,
  output logic                                             recoverValid_o,
  output renamePkg::mapPacketT [renamePkg::CommitWidth-1:0] recoverPacket_o,
  output logic                                             recoverDone_o,
  amtWriteIf.tableSide                                     store,
  releaseIf.producer                                       rel
);
  import renamePkg::*;

  localparam int GroupBits = LogRegBits - $clog2(CommitWidth);  // Groups of four entries
  localparam int LastGroup = NumLogRegs / CommitWidth - 1;

  recStateT               recState;
  logic   [GroupBits-1:0] groupCnt;  // Which four entries are on the bus this cycle

  logRegT  [CommitWidth-1:0] commitDest;
  physRegT [CommitWidth-1:0] commitPhys;
  logic    [CommitWidth-1:0] youngerHit;  // A younger valid slot names the same destination
  logRegT  [CommitWidth-1:0] recAddr;

  // Split the packets into destination and new physical register
  always_comb begin
    for (int s = 0; s < CommitWidth; s++) begin
      commitDest[s] = commitPacket_i[s].logDest;
      commitPhys[s] = commitPacket_i[s].physReg;
    end
  end

  // Slot 0 is oldest, so each slot only looks at higher slots
  always_comb begin
    youngerHit[0] = (commitValid_i[1] && (commitDest[1] == commitDest[0]))
                 || (commitValid_i[2] && (commitDest[2] == commitDest[0]))
                 || (commitValid_i[3] && (commitDest[3] == commitDest[0]));
    youngerHit[1] = (commitValid_i[2] && (commitDest[2] == commitDest[1]))
                 || (commitValid_i[3] && (commitDest[3] == commitDest[1]));
    youngerHit[2] = commitValid_i[3] && (commitDest[3] == commitDest[2]);
    youngerHit[3] = 1'b0;  // Youngest slot always writes when valid
  end

  // Only the youngest slot per destination updates the table
  always_comb begin
    for (int s = 0; s < CommitWidth; s++) begin
      store.writeEn[s]   = commitValid_i[s] && !youngerHit[s];
      store.writeAddr[s] = commitDest[s];
      store.writeData[s] = commitPhys[s];
    end
  end

  // A shadowed slot frees its own new register, which never became committed
  always_comb begin
    for (int s = 0; s < CommitWidth; s++) begin
      rel.relValid[s] = commitValid_i[s];
      rel.relPhys[s]  = youngerHit[s] ? commitPhys[s] : store.readData[s];
    end
  end

  // Entry 4k+j goes out on slot j during group k
  always_comb begin
    for (int j = 0; j < CommitWidth; j++) begin
      recAddr[j] = logRegT'(groupCnt * CommitWidth + j);
    end
  end

  // Reading the old mapping for release uses the same ports as recovery
  always_comb begin
    for (int j = 0; j < CommitWidth; j++) begin
      store.readAddr[j] = (recState == recActive) ? recAddr[j] : commitDest[j];
    end
  end

  always_comb begin
    for (int j = 0; j < CommitWidth; j++) begin
      recoverPacket_o[j].logDest = recAddr[j];
      recoverPacket_o[j].physReg = store.readData[j];
    end
  end

  assign recoverValid_o = (recState == recActive);
  assign recoverDone_o  = (recState == recActive) && (groupCnt == GroupBits'(LastGroup));

  // Eight groups back to back, start requests in flight are ignored
  always_ff @(posedge clk) begin
    if (reset) begin
      recState <= recIdle;
      groupCnt <= '0;
    end else begin
      case (recState)
        recIdle: begin
          if (recoverStart_i) begin
            recState <= recActive;
            groupCnt <= '0;
          end
        end
        recActive: begin
          groupCnt <= groupCnt + 1'b1;  // Wraps back to zero after the last group
          if (groupCnt == GroupBits'(LastGroup)) recState <= recIdle;
        end
        default: recState <= recIdle;
      endcase
    end
  end

  // Read ports belong to the dump, so retirement has to hold off
  assert property (@(posedge clk) disable iff (reset)
    (recState == recActive) |-> (commitValid_i == '0))
    else $error("archMapTable: commit presented during recovery");

endmodule

`default_nettype wire

// ==== design/commitFreeList.sv ====
// Free list of physical registers fed by retirement
// Circular buffer with head, tail and occupancy count
// Up to four compacted pushes and one pop per cycle
// Reset contents are the registers not used by the identity map
`default_nettype none

module commitFreeList (
  input  wire logic         clk,
  input  wire logic         reset,
  releaseIf.consumer        rel,
  input  wire logic         allocReq_i,
  output logic              allocValid_o,
  output renamePkg::physRegT allocPhys_o
);
  import renamePkg::*;

  localparam int PushBits = $clog2(CommitWidth + 1);  // Counts 0 to CommitWidth pushes

  physRegT                  freeBuf [NumPhysRegs];
  logic [PhysRegBits-1:0]   headPtr;   // Next register handed to rename
  logic [PhysRegBits-1:0]   tailPtr;   // First empty slot
  logic [FreeCntBits-1:0]   freeCnt;

  logic [PushBits-1:0]                     pushCnt;
  logic [CommitWidth-1:0][PhysRegBits-1:0] pushPtr;
  logic                                    popFire;

  // Running count packs valid slots into consecutive tail entries
  always_comb begin
    pushCnt = '0;
    for (int s = 0; s < CommitWidth; s++) begin
      pushPtr[s]    = tailPtr + PhysRegBits'(pushCnt);  // Wraps with the buffer
      pushCnt       = pushCnt + PushBits'(rel.relValid[s]);
    end
  end

  assign allocValid_o = (freeCnt != '0);
  assign allocPhys_o  = freeBuf[headPtr];
  assign popFire      = allocReq_i && allocValid_o;

  // Payload entries only get loaded with the initial free registers
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NumPhysRegs - NumLogRegs; i++) begin
        freeBuf[i] <= physRegT'(NumLogRegs + i);
      end
    end else begin
      for (int s = 0; s < CommitWidth; s++) begin
        if (rel.relValid[s]) freeBuf[pushPtr[s]] <= rel.relPhys[s];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      headPtr <= '0;
      tailPtr <= PhysRegBits'(NumPhysRegs - NumLogRegs);  // Just past the initial block
      freeCnt <= FreeCntBits'(NumPhysRegs - NumLogRegs);
    end else begin
      if (popFire) headPtr <= headPtr + 1'b1;
      tailPtr <= tailPtr + PhysRegBits'(pushCnt);
      freeCnt <= freeCnt + FreeCntBits'(pushCnt) - FreeCntBits'(popFire);
    end
  end

  // Map and list together never own more than the physical register file
  assert property (@(posedge clk) disable iff (reset)
    (int'(freeCnt) + int'(pushCnt) - int'(popFire)) <= NumPhysRegs)
    else $error("commitFreeList: overflow, %0d held plus %0d pushed", freeCnt, pushCnt);

  // Rename must watch allocValid_o before asking for a register
  assert property (@(posedge clk) disable iff (reset) allocReq_i |-> allocValid_o)
    else $error("commitFreeList: pop requested while empty");

endmodule

`default_nettype wire

// ==== design/renameRetire.sv ====
// Retirement side of the rename core
// Joins the map table control, its storage and the free list
// Plain ports for commit, recovery and allocation
`default_nettype none

module renameRetire (
  input  wire logic                                              clk,
  input  wire logic                                              reset,
  input  wire logic [renamePkg::CommitWidth-1:0]                 commitValid_i,
  input  wire renamePkg::mapPacketT [renamePkg::CommitWidth-1:0] commitPacket_i,
  input  wire logic                                              recoverStart_i,
  output logic                                                   recoverValid_o,
  output renamePkg::mapPacketT [renamePkg::CommitWidth-1:0]      recoverPacket_o,
  output logic                                                   recoverDone_o,
  input  wire logic                                              allocReq_i,
  output logic                                                   allocValid_o,
  output renamePkg::physRegT                                     allocPhys_o
);

  amtWriteIf storeBus ();  // Table control to register array
  releaseIf  relBus ();    // Displaced registers into the free list

  // Filters the commit window and runs the recovery dump
  archMapTable u_table (
    .clk             (clk),
    .reset           (reset),
    .commitValid_i   (commitValid_i),
    .commitPacket_i  (commitPacket_i),
    .recoverStart_i  (recoverStart_i),
    .recoverValid_o  (recoverValid_o),
    .recoverPacket_o (recoverPacket_o),
    .recoverDone_o   (recoverDone_o),
    .store           (storeBus.tableSide),
    .rel             (relBus.producer)
  );

  amtStorage u_storage (
    .clk   (clk),
    .reset (reset),
    .port  (storeBus.storageSide)
  );

  // Hands freed registers back to rename one per cycle
  commitFreeList u_freeList (
    .clk          (clk),
    .reset        (reset),
    .rel          (relBus.consumer),
    .allocReq_i   (allocReq_i),
    .allocValid_o (allocValid_o),
    .allocPhys_o  (allocPhys_o)
  );

endmodule

`default_nettype wire

// ==== verif/renameRetireTb.sv ====
// Testbench for the rename retirement block
// Clock, reset and seeded random commit, pop and recovery stimulus
// Reference model of the committed map and the free list
// Per-test summary lines and a closing count line
`default_nettype none

module renameRetireTb;
  import renamePkg::*;

  logic                        clk;
  logic                        reset;
  logic    [CommitWidth-1:0]   commitValid;
  mapPacketT [CommitWidth-1:0] commitPacket;
  logic                        recoverStart;
  logic                        recoverValid;
  mapPacketT [CommitWidth-1:0] recoverPacket;
  logic                        recoverDone;
  logic                        allocReq;
  logic                        allocValid;
  physRegT                     allocPhys;

  integer seed = 87;
  int     modelMap [NumLogRegs];  // Committed mapping per logical register
  int     freeQ [$];              // Free list, head at index 0
  int     allocated [$];          // Registers handed out but not yet committed
  int     checkCount = 0;
  int     errorCount = 0;
  int     testChecks = 0;
  int     testErrors = 0;

  renameRetire u_dut (
    .clk             (clk),
    .reset           (reset),
    .commitValid_i   (commitValid),
    .commitPacket_i  (commitPacket),
    .recoverStart_i  (recoverStart),
    .recoverValid_o  (recoverValid),
    .recoverPacket_o (recoverPacket),
    .recoverDone_o   (recoverDone),
    .allocReq_i      (allocReq),
    .allocValid_o    (allocValid),
    .allocPhys_o     (allocPhys)
  );

  always #20 clk = ~clk;  // 40 unit period

  task automatic abortRun(string why);
    $display("Run stopped: %s", why);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic compareValue(string what, int got, int expected);
    checkCount++;
    if (got != expected) begin
      errorCount++;
      $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  task automatic finishTest(string name);
    $display("Test %s: %0d checks, %0d errors", name, checkCount - testChecks,
             errorCount - testErrors);
    testChecks = checkCount;
    testErrors = errorCount;
  endtask

  task automatic clearInputs();
    commitValid  = '0;
    commitPacket = '0;
    recoverStart = 1'b0;
    allocReq     = 1'b0;
  endtask

  // Older slots shadowed by a younger same destination give back their own register
  task automatic applyCommit();
    bit shadowed [CommitWidth];
    int relReg [CommitWidth];
    for (int s = 0; s < CommitWidth; s++) begin
      shadowed[s] = 1'b0;
      for (int t = s + 1; t < CommitWidth; t++) begin
        if (commitValid[t] && (commitPacket[t].logDest == commitPacket[s].logDest)) begin
          shadowed[s] = 1'b1;
        end
      end
      relReg[s] = shadowed[s] ? int'(commitPacket[s].physReg)
                              : modelMap[int'(commitPacket[s].logDest)];
    end
    for (int s = 0; s < CommitWidth; s++) begin
      if (commitValid[s] && !shadowed[s]) begin
        modelMap[int'(commitPacket[s].logDest)] = int'(commitPacket[s].physReg);
      end
    end
    for (int s = 0; s < CommitWidth; s++) begin
      if (commitValid[s]) freeQ.push_back(relReg[s]);  // Tail order follows slot order
    end
  endtask

  // Checks the pop port and the idle recovery outputs mid-cycle, then mirrors the edge
  task automatic stepCycle();
    logic popNow;
    @(negedge clk);
    compareValue("allocValid_o", int'(allocValid), (freeQ.size() != 0) ? 1 : 0);
    if (freeQ.size() != 0) compareValue("allocPhys_o", int'(allocPhys), freeQ[0]);
    compareValue("recoverValid_o", int'(recoverValid), 0);  // No dump runs outside checkRecovery
    compareValue("recoverDone_o", int'(recoverDone), 0);
    popNow = allocReq && (freeQ.size() != 0);
    @(posedge clk);
    if (popNow) allocated.push_back(freeQ.pop_front());  // Pop lands before the pushes
    applyCommit();
    #2;
  endtask

  // Fills valid slots only while allocated registers remain
  task automatic driveWindow(int destRange, int validPct, bit wantPop);
    clearInputs();
    for (int s = 0; s < CommitWidth; s++) begin
      if ((allocated.size() != 0) && (($unsigned($random(seed)) % 100) < validPct)) begin
        commitValid[s]          = 1'b1;
        commitPacket[s].logDest = logRegT'($unsigned($random(seed)) % destRange);
        commitPacket[s].physReg = physRegT'(allocated.pop_front());
      end
    end
    allocReq = wantPop && (freeQ.size() != 0);
  endtask

  task automatic checkRecovery();
    int waitCnt;
    int groupIdx;
    int entry;
    clearInputs();
    recoverStart = 1'b1;
    stepCycle();
    recoverStart = 1'b0;
    waitCnt = 0;
    @(negedge clk);
    while ((recoverValid !== 1'b1) && (waitCnt < 4)) begin
      waitCnt++;
      @(negedge clk);
    end
    if (recoverValid !== 1'b1) begin
      errorCount++;
      $display("Timeout at %0t: recoverValid_o never rose after recoverStart_i", $time);
    end
    compareValue("recovery start delay", waitCnt, 0);
    groupIdx = 0;
    while ((recoverValid === 1'b1) && (groupIdx < 16)) begin  // Twice the dump length
      for (int j = 0; j < CommitWidth && groupIdx < NumLogRegs / CommitWidth; j++) begin
        entry = groupIdx * CommitWidth + j;  // Slot j of group k holds entry 4k+j
        compareValue("recoverPacket_o logDest", int'(recoverPacket[j].logDest), entry);
        compareValue("recoverPacket_o physReg", int'(recoverPacket[j].physReg),
                     modelMap[entry]);
      end
      compareValue("recoverDone_o", int'(recoverDone), (groupIdx == 7) ? 1 : 0);
      groupIdx++;
      @(negedge clk);
    end
    if (recoverValid === 1'b1) begin
      errorCount++;
      $display("Timeout at %0t: recoverValid_o stayed high past the dump", $time);
    end
    compareValue("recoverValid_o high cycles", groupIdx, NumLogRegs / CommitWidth);
    @(posedge clk);
    #2;
  endtask

  initial begin
    #(40 * 5000);
    abortRun("simulation exceeded its cycle limit");
  end

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    clearInputs();
    for (int i = 0; i < NumLogRegs; i++) modelMap[i] = i;  // Identity map
    for (int i = NumLogRegs; i < NumPhysRegs; i++) freeQ.push_back(i);
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;

    // Drain the whole list, then dump the untouched map
    for (int i = 0; i < NumPhysRegs - NumLogRegs; i++) begin
      clearInputs();
      allocReq = 1'b1;
      stepCycle();
    end
    clearInputs();
    stepCycle();  // List must now read empty
    checkRecovery();
    finishTest("reset state");

    for (int i = 0; i < 12; i++) begin
      clearInputs();
      commitValid[0]          = 1'b1;
      commitPacket[0].logDest = logRegT'($unsigned($random(seed)) % NumLogRegs);
      commitPacket[0].physReg = physRegT'(allocated.pop_front());
      stepCycle();
    end
    for (int i = 0; i < 12; i++) begin
      clearInputs();
      allocReq = (freeQ.size() != 0);
      stepCycle();
    end
    finishTest("single-slot commits");

    // Three destinations keep collisions frequent
    for (int i = 0; i < 24; i++) begin
      driveWindow(3, 75, 1'b1);
      stepCycle();
      clearInputs();
      allocReq = (freeQ.size() != 0);
      stepCycle();
    end
    checkRecovery();
    finishTest("same-destination windows");

    for (int i = 0; i < 150; i++) begin
      driveWindow(NumLogRegs, 50, ($unsigned($random(seed)) % 2) == 0);
      stepCycle();
    end
    checkRecovery();
    finishTest("recovery contents");

    for (int i = 0; i < 400; i++) begin
      driveWindow(NumLogRegs, 40, ($unsigned($random(seed)) % 3) != 0);
      stepCycle();
    end
    clearInputs();
    stepCycle();
    finishTest("mixed traffic");

    $display("Totals: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/renamePkg.sv
design/amtWriteIf.sv
design/releaseIf.sv
design/amtStorage.sv
design/archMapTable.sv
design/commitFreeList.sv
design/renameRetire.sv
verif/renameRetireTb.sv

// ==== Makefile ====
# Verilator build and run for the rename retirement testbench

VERILATOR ?= verilator
TOP       ?= renameRetireTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= >>> PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)
